// File: rtl/mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} alu_op_t;

	// lui takes the raw immediate and the alu moves it to the upper half.
	typedef enum logic [1:0] {IMM_SIGN, IMM_ZERO, IMM_UPPER} imm_kind_t;

	typedef enum logic [1:0] {FWD_D_RF, FWD_D_MEM, FWD_D_WB} fwd_d_t;
	typedef enum logic [1:0] {FWD_E_LATCH, FWD_E_MEM, FWD_E_WB} fwd_e_t;
	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_RET} wb_src_t;

	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

endpackage

// File: rtl/decode_if.sv
`timescale 1ns/1ps

interface decode_if;
	mips_pkg::reg_addr_t rs, rt, rd;
	logic uses_rs, uses_rt;
	logic reg_we;
	mips_pkg::reg_addr_t dst;
	mips_pkg::imm_kind_t imm_kind;
	logic alu_src; // second alu operand is the immediate.
	mips_pkg::alu_op_t alu_op;
	logic mem_read, mem_write;
	mips_pkg::wb_src_t wb_src;
	logic branch, branch_ne, jump;

	modport dec(output rs, rt, rd, uses_rs, uses_rt, reg_we, dst, imm_kind, alu_src,
		alu_op, mem_read, mem_write, wb_src, branch, branch_ne, jump);
	modport pipe(input rs, rt, rd, uses_rs, uses_rt, reg_we, dst, imm_kind, alu_src,
		alu_op, mem_read, mem_write, wb_src, branch, branch_ne, jump);
endinterface

// File: rtl/hazard_if.sv
`timescale 1ns/1ps

interface hazard_if;
	mips_pkg::reg_addr_t d_rs, d_rt;
	logic d_uses_rs, d_uses_rt, d_is_branch;
	mips_pkg::reg_addr_t e_rs, e_rt, e_dst;
	logic e_we, e_mem_read;
	mips_pkg::reg_addr_t m_dst, w_dst;
	logic m_we, m_mem_read, w_we;
	mips_pkg::fwd_d_t fwd_d1, fwd_d2;
	mips_pkg::fwd_e_t fwd_e1, fwd_e2;
	logic stall;

	modport pipe(output d_rs, d_rt, d_uses_rs, d_uses_rt, d_is_branch, e_rs, e_rt, e_dst,
		e_we, e_mem_read, m_dst, m_we, m_mem_read, w_dst, w_we,
		input fwd_d1, fwd_d2, fwd_e1, fwd_e2, stall);
	modport haz(input d_rs, d_rt, d_uses_rs, d_uses_rt, d_is_branch, e_rs, e_rt, e_dst,
		e_we, e_mem_read, m_dst, m_we, m_mem_read, w_dst, w_we,
		output fwd_d1, fwd_d2, fwd_e1, fwd_e2, stall);
endinterface

// File: rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
	input mips_pkg::word_t instr,
	decode_if.dec dec
);

	logic [5:0] opcode, funct;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		dec.rs = instr[25:21];
		dec.rt = instr[20:16];
		dec.rd = instr[15:11];
		dec.uses_rs = 1'b0;
		dec.uses_rt = 1'b0;
		dec.reg_we = 1'b0;
		dec.dst = dec.rt; // I-type destination.
		dec.imm_kind = mips_pkg::IMM_SIGN;
		dec.alu_src = 1'b0;
		dec.alu_op = mips_pkg::ALU_ADD;
		dec.mem_read = 1'b0;
		dec.mem_write = 1'b0;
		dec.wb_src = mips_pkg::WB_ALU;
		dec.branch = 1'b0;
		dec.branch_ne = 1'b0;
		dec.jump = 1'b0;
		case (opcode)
			mips_pkg::OP_SPECIAL: begin
				dec.dst = dec.rd;
				// an unknown function code leaves every enable low.
				if (funct == mips_pkg::FN_ADDU || funct == mips_pkg::FN_SUBU ||
						funct == mips_pkg::FN_AND || funct == mips_pkg::FN_OR ||
						funct == mips_pkg::FN_SLT) begin
					dec.uses_rs = 1'b1;
					dec.uses_rt = 1'b1;
					dec.reg_we = 1'b1;
				end
				case (funct)
					mips_pkg::FN_SUBU: dec.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: dec.alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR: dec.alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_SLT: dec.alu_op = mips_pkg::ALU_SLT;
					default: dec.alu_op = mips_pkg::ALU_ADD;
				endcase
			end
			mips_pkg::OP_ADDIU: begin
				dec.uses_rs = 1'b1;
				dec.reg_we = 1'b1;
				dec.alu_src = 1'b1;
			end
			mips_pkg::OP_ORI: begin
				dec.uses_rs = 1'b1;
				dec.reg_we = 1'b1;
				dec.alu_src = 1'b1;
				dec.imm_kind = mips_pkg::IMM_ZERO;
				dec.alu_op = mips_pkg::ALU_OR;
			end
			mips_pkg::OP_LUI: begin
				dec.reg_we = 1'b1;
				dec.alu_src = 1'b1;
				dec.imm_kind = mips_pkg::IMM_UPPER;
				dec.alu_op = mips_pkg::ALU_LUI;
			end
			mips_pkg::OP_LW: begin
				dec.uses_rs = 1'b1;
				dec.reg_we = 1'b1;
				dec.alu_src = 1'b1;
				dec.mem_read = 1'b1;
				dec.wb_src = mips_pkg::WB_LOAD;
			end
			mips_pkg::OP_SW: begin
				dec.uses_rs = 1'b1;
				dec.uses_rt = 1'b1; // store data.
				dec.alu_src = 1'b1;
				dec.mem_write = 1'b1;
			end
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
				dec.uses_rs = 1'b1;
				dec.uses_rt = 1'b1;
				dec.branch = 1'b1;
				dec.branch_ne = (opcode == mips_pkg::OP_BNE);
			end
			mips_pkg::OP_J: dec.jump = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	hazard_if.haz haz
);

	logic m_alu_we; // memory stage holds a result that its alu produced.
	logic dep_e, dep_m;

	function automatic logic hit(input mips_pkg::reg_addr_t src, input logic we,
			input mips_pkg::reg_addr_t dst);
		return we && dst != 5'd0 && dst == src;
	endfunction

	assign m_alu_we = haz.m_we && !haz.m_mem_read;

	// the memory stage is newer than writeback, so it wins.
	assign haz.fwd_d1 = hit(haz.d_rs, m_alu_we, haz.m_dst) ? mips_pkg::FWD_D_MEM :
		hit(haz.d_rs, haz.w_we, haz.w_dst) ? mips_pkg::FWD_D_WB : mips_pkg::FWD_D_RF;
	assign haz.fwd_d2 = hit(haz.d_rt, m_alu_we, haz.m_dst) ? mips_pkg::FWD_D_MEM :
		hit(haz.d_rt, haz.w_we, haz.w_dst) ? mips_pkg::FWD_D_WB : mips_pkg::FWD_D_RF;

	assign haz.fwd_e1 = hit(haz.e_rs, m_alu_we, haz.m_dst) ? mips_pkg::FWD_E_MEM :
		hit(haz.e_rs, haz.w_we, haz.w_dst) ? mips_pkg::FWD_E_WB : mips_pkg::FWD_E_LATCH;
	assign haz.fwd_e2 = hit(haz.e_rt, m_alu_we, haz.m_dst) ? mips_pkg::FWD_E_MEM :
		hit(haz.e_rt, haz.w_we, haz.w_dst) ? mips_pkg::FWD_E_WB : mips_pkg::FWD_E_LATCH;

	assign dep_e = (haz.d_uses_rs && hit(haz.d_rs, haz.e_we, haz.e_dst)) ||
		(haz.d_uses_rt && hit(haz.d_rt, haz.e_we, haz.e_dst));
	assign dep_m = (haz.d_uses_rs && hit(haz.d_rs, haz.m_we, haz.m_dst)) ||
		(haz.d_uses_rt && hit(haz.d_rt, haz.m_we, haz.m_dst));

	// branches compare in decode, so they cannot wait for execute forwarding.
	assign haz.stall = (dep_e && (haz.e_mem_read || haz.d_is_branch)) ||
		(dep_m && haz.d_is_branch && haz.m_mem_read);

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic rst_n,
	input mips_pkg::reg_addr_t raddr1,
	input mips_pkg::reg_addr_t raddr2,
	output mips_pkg::word_t rdata1,
	output mips_pkg::word_t rdata2,
	input logic we,
	input mips_pkg::reg_addr_t waddr,
	input mips_pkg::word_t wdata
);

	mips_pkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// a read of the register being written sees the new value.
	assign rdata1 = (raddr1 == 5'd0) ? '0 : (we && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
	input mips_pkg::word_t a,
	input mips_pkg::word_t b,
	input mips_pkg::alu_op_t op,
	output mips_pkg::word_t result
);

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD: result = a + b; // wraps without an overflow trap.
			mips_pkg::ALU_SUB: result = a - b;
			mips_pkg::ALU_AND: result = a & b;
			mips_pkg::ALU_OR: result = a | b;
			mips_pkg::ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
			mips_pkg::ALU_LUI: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

endmodule

// File: rtl/cpu.sv
`timescale 1ns/1ps

module cpu #(
	parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input logic clk,
	input logic rst_n,
	output mips_pkg::word_t instr_addr,
	input mips_pkg::word_t instr,
	output mips_pkg::word_t data_addr,
	output mips_pkg::word_t data_wdata,
	output logic data_we,
	input mips_pkg::word_t data_rdata,
	output mips_pkg::word_t wb_pc,
	output logic wb_we,
	output mips_pkg::reg_addr_t wb_reg,
	output mips_pkg::word_t wb_data
);

	mips_pkg::word_t pc, next_pc;
	mips_pkg::word_t d_pc, d_instr, d_pc4, d_imm, d_rf1, d_rf2, d_op1, d_op2;
	mips_pkg::word_t br_target, j_target;
	logic br_taken;

	mips_pkg::word_t e_pc, e_op1, e_op2, e_imm, e_a, e_b, e_fwd2, e_alu;
	logic e_we, e_mem_read, e_mem_write, e_alu_src;
	mips_pkg::reg_addr_t e_rs, e_rt, e_dst;
	mips_pkg::alu_op_t e_alu_op;
	mips_pkg::wb_src_t e_wb_src;

	mips_pkg::word_t m_pc, m_alu, m_store;
	logic m_we, m_mem_read, m_mem_write;
	mips_pkg::reg_addr_t m_dst;
	mips_pkg::wb_src_t m_wb_src;

	mips_pkg::word_t w_pc, w_alu, w_load, w_data;
	logic w_we;
	mips_pkg::reg_addr_t w_dst;
	mips_pkg::wb_src_t w_wb_src;

	function automatic mips_pkg::word_t pick_d(input mips_pkg::fwd_d_t sel,
			input mips_pkg::word_t rf, input mips_pkg::word_t mem, input mips_pkg::word_t wb);
		case (sel)
			mips_pkg::FWD_D_MEM: return mem;
			mips_pkg::FWD_D_WB: return wb;
			default: return rf;
		endcase
	endfunction

	function automatic mips_pkg::word_t pick_e(input mips_pkg::fwd_e_t sel,
			input mips_pkg::word_t latched, input mips_pkg::word_t mem,
			input mips_pkg::word_t wb);
		case (sel)
			mips_pkg::FWD_E_MEM: return mem;
			mips_pkg::FWD_E_WB: return wb;
			default: return latched;
		endcase
	endfunction

	decode_if dec_bus ();
	hazard_if haz_bus ();

	decoder decoder (
		.instr(d_instr),
		.dec(dec_bus)
	);

	hazard_unit hazard_unit (
		.haz(haz_bus)
	);

	assign haz_bus.d_rs = dec_bus.rs;
	assign haz_bus.d_rt = dec_bus.rt;
	assign haz_bus.d_uses_rs = dec_bus.uses_rs;
	assign haz_bus.d_uses_rt = dec_bus.uses_rt;
	assign haz_bus.d_is_branch = dec_bus.branch;
	assign haz_bus.e_rs = e_rs;
	assign haz_bus.e_rt = e_rt;
	assign haz_bus.e_dst = e_dst;
	assign haz_bus.e_we = e_we;
	assign haz_bus.e_mem_read = e_mem_read;
	assign haz_bus.m_dst = m_dst;
	assign haz_bus.m_we = m_we;
	assign haz_bus.m_mem_read = m_mem_read;
	assign haz_bus.w_dst = w_dst;
	assign haz_bus.w_we = w_we;

	// a redirect from decode lands after the delay slot being fetched now.
	always_comb begin
		if (br_taken)
			next_pc = br_target;
		else if (dec_bus.jump)
			next_pc = j_target;
		else
			next_pc = pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
			d_pc <= RESET_PC;
			d_instr <= '0; // decodes as a no-op.
		end else if (!haz_bus.stall) begin
			pc <= next_pc;
			d_pc <= pc;
			d_instr <= instr;
		end
	end

	assign instr_addr = pc;

	reg_file reg_file (
		.clk(clk),
		.rst_n(rst_n),
		.raddr1(dec_bus.rs),
		.raddr2(dec_bus.rt),
		.rdata1(d_rf1),
		.rdata2(d_rf2),
		.we(w_we),
		.waddr(w_dst),
		.wdata(w_data)
	);

	always_comb begin
		case (dec_bus.imm_kind)
			mips_pkg::IMM_SIGN: d_imm = {{16{d_instr[15]}}, d_instr[15:0]};
			default: d_imm = {16'h0000, d_instr[15:0]};
		endcase
	end

	assign d_op1 = pick_d(haz_bus.fwd_d1, d_rf1, m_alu, w_data);
	assign d_op2 = pick_d(haz_bus.fwd_d2, d_rf2, m_alu, w_data);
	assign d_pc4 = d_pc + 32'd4;
	assign br_target = d_pc4 + {{14{d_instr[15]}}, d_instr[15:0], 2'b00};
	assign j_target = {d_pc4[31:28], d_instr[25:0], 2'b00};
	assign br_taken = dec_bus.branch && ((d_op1 == d_op2) != dec_bus.branch_ne);

	// a stall leaves a bubble in execute.
	always_ff @(posedge clk) begin
		if (!rst_n || haz_bus.stall) begin
			e_we <= 1'b0;
			e_mem_read <= 1'b0;
			e_mem_write <= 1'b0;
		end else begin
			e_we <= dec_bus.reg_we;
			e_mem_read <= dec_bus.mem_read;
			e_mem_write <= dec_bus.mem_write;
		end
	end

	always_ff @(posedge clk) begin
		e_pc <= d_pc;
		e_op1 <= d_op1;
		e_op2 <= d_op2;
		e_imm <= d_imm;
		e_rs <= dec_bus.rs;
		e_rt <= dec_bus.rt;
		e_dst <= dec_bus.dst;
		e_alu_op <= dec_bus.alu_op;
		e_alu_src <= dec_bus.alu_src;
		e_wb_src <= dec_bus.wb_src;
	end

	assign e_a = pick_e(haz_bus.fwd_e1, e_op1, m_alu, w_data);
	assign e_fwd2 = pick_e(haz_bus.fwd_e2, e_op2, m_alu, w_data);
	assign e_b = e_alu_src ? e_imm : e_fwd2;

	alu alu (
		.a(e_a),
		.b(e_b),
		.op(e_alu_op),
		.result(e_alu)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_we <= 1'b0;
			m_mem_read <= 1'b0;
			m_mem_write <= 1'b0;
		end else begin
			m_we <= e_we;
			m_mem_read <= e_mem_read;
			m_mem_write <= e_mem_write;
		end
	end

	always_ff @(posedge clk) begin
		m_pc <= e_pc;
		m_alu <= e_alu;
		m_store <= e_fwd2;
		m_dst <= e_dst;
		m_wb_src <= e_wb_src;
	end

	assign data_addr = m_alu;
	assign data_wdata = m_store;
	assign data_we = m_mem_write;

	always_ff @(posedge clk) begin
		if (!rst_n)
			w_we <= 1'b0;
		else
			w_we <= m_we;
	end

	always_ff @(posedge clk) begin
		w_pc <= m_pc;
		w_alu <= m_alu;
		w_load <= data_rdata; // the bus answers in the same cycle.
		w_dst <= m_dst;
		w_wb_src <= m_wb_src;
	end

	always_comb begin
		case (w_wb_src)
			mips_pkg::WB_LOAD: w_data = w_load;
			mips_pkg::WB_RET: w_data = w_pc + 32'd8;
			default: w_data = w_alu;
		endcase
	end

	assign wb_pc = w_pc;
	assign wb_we = w_we;
	assign wb_reg = w_dst;
	assign wb_data = w_data;

endmodule

// File: test/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

	localparam int PROGRAM_WORDS = 58; // instruction words over all tests.
	localparam int CYCLE_LIMIT = 5 * PROGRAM_WORDS + 200;

	logic clk = 1'b0;
	logic rst_n;
	mips_pkg::word_t instr_addr, instr, data_addr, data_wdata, data_rdata;
	mips_pkg::word_t wb_pc, wb_data;
	logic data_we, wb_we;
	mips_pkg::reg_addr_t wb_reg;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] got_pc [$], got_reg [$], got_data [$], got_addr [$], got_store [$];
	logic [31:0] exp_pc [$], exp_reg [$], exp_data [$], exp_addr [$], exp_store [$];
	int got_base, store_base;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	cpu #(.RESET_PC(32'h0000_0000)) dut (
		.clk(clk),
		.rst_n(rst_n),
		.instr_addr(instr_addr),
		.instr(instr),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_we(data_we),
		.data_rdata(data_rdata),
		.wb_pc(wb_pc),
		.wb_we(wb_we),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] mem_fill(input logic [31:0] addr);
		return 32'hd00d_0000 ^ addr;
	endfunction

	function automatic logic [31:0] alu_r(input logic [5:0] fn, input int rd, input int rs,
			input int rt);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] imm_op(input logic [5:0] op, input int rt, input int rs,
			input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] jump_to(input logic [31:0] target);
		return {mips_pkg::OP_J, target[27:2]};
	endfunction

	assign instr = imem[instr_addr[9:2]];
	assign data_rdata = rst_n ? dmem[data_addr[9:2]] : 32'h0;

	// reset reloads the data memory with a word that encodes its own address.
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++)
				dmem[i] <= mem_fill(i * 4);
		end else if (data_we) begin
			dmem[data_addr[9:2]] <= data_wdata;
		end
	end

	always @(negedge clk) begin
		if (rst_n && wb_we) begin
			got_pc.push_back(wb_pc);
			got_reg.push_back({27'd0, wb_reg});
			got_data.push_back(wb_data);
		end
		if (rst_n && data_we) begin
			got_addr.push_back(data_addr);
			got_store.push_back(data_wdata);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("checks %0d, errors %0d", checks, errors);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic put_instr(input logic [31:0] addr, input logic [31:0] word);
		imem[addr[9:2]] = word;
	endtask

	task automatic expect_wb(input logic [31:0] pc, input int rd, input logic [31:0] data);
		exp_pc.push_back(pc);
		exp_reg.push_back(rd);
		exp_data.push_back(data);
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr.push_back(addr);
		exp_store.push_back(data);
	endtask

	task automatic begin_test();
		@(posedge clk);
		rst_n <= 1'b0;
		@(negedge clk);
		for (int i = 0; i < 256; i++)
			imem[i] = 32'h0; // all zero decodes as a no-op.
		exp_pc.delete();
		exp_reg.delete();
		exp_data.delete();
		exp_addr.delete();
		exp_store.delete();
		got_base = got_pc.size();
		store_base = got_addr.size();
	endtask

	task automatic release_reset();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic finish_program();
		while (got_pc.size() - got_base < exp_pc.size())
			@(negedge clk);
		repeat (5) @(negedge clk); // a late stray write would reach writeback by now.
		check("wb event count", got_pc.size() - got_base, exp_pc.size());
		for (int i = 0; i < exp_pc.size() && got_base + i < got_pc.size(); i++) begin
			check("wb_pc", got_pc[got_base + i], exp_pc[i]);
			check("wb_reg", got_reg[got_base + i], exp_reg[i]);
			check("wb_data", got_data[got_base + i], exp_data[i]);
		end
		check("store count", got_addr.size() - store_base, exp_addr.size());
		for (int i = 0; i < exp_addr.size() && store_base + i < got_addr.size(); i++) begin
			check("data_addr", got_addr[store_base + i], exp_addr[i]);
			check("data_wdata", got_store[store_base + i], exp_store[i]);
		end
	endtask

	task automatic fetch_after_reset();
		begin_test();
		release_reset();
		for (int k = 0; k < 8; k++) begin
			@(negedge clk);
			check("instr_addr", instr_addr, 4 * k);
			check("wb_we", {31'd0, wb_we}, 32'h0);
			check("data_we", {31'd0, data_we}, 32'h0);
		end
		finish_program();
	endtask

	task automatic alu_chain();
		begin_test();
		put_instr(32'h00, imm_op(mips_pkg::OP_ADDIU, 1, 0, 32'h1234));
		put_instr(32'h04, imm_op(mips_pkg::OP_ORI, 2, 1, 32'hf00f));
		put_instr(32'h08, imm_op(mips_pkg::OP_LUI, 3, 0, 32'h8001));
		put_instr(32'h0c, alu_r(mips_pkg::FN_ADDU, 4, 3, 2));
		put_instr(32'h10, alu_r(mips_pkg::FN_SUBU, 5, 4, 1));
		put_instr(32'h14, alu_r(mips_pkg::FN_AND, 6, 5, 2));
		put_instr(32'h18, alu_r(mips_pkg::FN_OR, 7, 6, 3));
		put_instr(32'h1c, alu_r(mips_pkg::FN_SLT, 8, 7, 1));
		put_instr(32'h20, imm_op(mips_pkg::OP_ADDIU, 0, 0, 32'h55));
		put_instr(32'h24, alu_r(mips_pkg::FN_ADDU, 9, 0, 8));
		put_instr(32'h28, imm_op(mips_pkg::OP_ADDIU, 10, 0, 32'hffff));
		put_instr(32'h2c, alu_r(mips_pkg::FN_SLT, 11, 10, 0));
		put_instr(32'h30, jump_to(32'h30));
		expect_wb(32'h00, 1, 32'h0000_1234);
		expect_wb(32'h04, 2, 32'h0000_f23f);
		expect_wb(32'h08, 3, 32'h8001_0000);
		expect_wb(32'h0c, 4, 32'h8001_f23f);
		expect_wb(32'h10, 5, 32'h8001_e00b);
		expect_wb(32'h14, 6, 32'h0000_e00b);
		expect_wb(32'h18, 7, 32'h8001_e00b);
		expect_wb(32'h1c, 8, 32'h1); // $7 is negative as a signed word.
		expect_wb(32'h20, 0, 32'h55); // reported, but $0 keeps reading zero.
		expect_wb(32'h24, 9, 32'h1);
		expect_wb(32'h28, 10, 32'hffff_ffff);
		expect_wb(32'h2c, 11, 32'h1);
		release_reset();
		finish_program();
	endtask

	task automatic load_use();
		begin_test();
		put_instr(32'h00, imm_op(mips_pkg::OP_ADDIU, 1, 0, 32'h40));
		put_instr(32'h04, imm_op(mips_pkg::OP_ADDIU, 2, 0, 32'h7bcd));
		put_instr(32'h08, imm_op(mips_pkg::OP_LUI, 3, 0, 32'ha5a5));
		put_instr(32'h0c, alu_r(mips_pkg::FN_OR, 3, 3, 2));
		put_instr(32'h10, imm_op(mips_pkg::OP_SW, 3, 1, 8));
		put_instr(32'h14, imm_op(mips_pkg::OP_LW, 4, 1, 8));
		put_instr(32'h18, alu_r(mips_pkg::FN_ADDU, 5, 4, 1));
		put_instr(32'h1c, imm_op(mips_pkg::OP_LW, 6, 1, 32'h10));
		put_instr(32'h20, alu_r(mips_pkg::FN_SUBU, 7, 6, 4));
		put_instr(32'h24, imm_op(mips_pkg::OP_SW, 7, 0, 4));
		put_instr(32'h28, jump_to(32'h28));
		expect_wb(32'h00, 1, 32'h40);
		expect_wb(32'h04, 2, 32'h7bcd);
		expect_wb(32'h08, 3, 32'ha5a5_0000);
		expect_wb(32'h0c, 3, 32'ha5a5_7bcd);
		expect_wb(32'h14, 4, 32'ha5a5_7bcd);
		expect_wb(32'h18, 5, 32'ha5a5_7c0d);
		expect_wb(32'h1c, 6, mem_fill(32'h50));
		expect_wb(32'h20, 7, mem_fill(32'h50) - 32'ha5a5_7bcd);
		expect_store(32'h48, 32'ha5a5_7bcd);
		expect_store(32'h04, mem_fill(32'h50) - 32'ha5a5_7bcd);
		release_reset();
		finish_program();
	endtask

	task automatic branch_paths();
		begin_test();
		put_instr(32'h00, imm_op(mips_pkg::OP_ADDIU, 1, 0, 5));
		put_instr(32'h04, imm_op(mips_pkg::OP_ADDIU, 2, 0, 5));
		put_instr(32'h08, imm_op(mips_pkg::OP_BEQ, 2, 1, 5)); // taken to 0x20.
		put_instr(32'h0c, imm_op(mips_pkg::OP_ADDIU, 3, 0, 32'h11));
		put_instr(32'h10, imm_op(mips_pkg::OP_ADDIU, 12, 0, 32'h99));
		put_instr(32'h20, imm_op(mips_pkg::OP_ADDIU, 5, 0, 6));
		put_instr(32'h24, imm_op(mips_pkg::OP_BEQ, 1, 5, 6)); // not taken.
		put_instr(32'h28, imm_op(mips_pkg::OP_ADDIU, 6, 0, 32'h22));
		put_instr(32'h2c, imm_op(mips_pkg::OP_ADDIU, 7, 5, 1));
		put_instr(32'h30, imm_op(mips_pkg::OP_BNE, 5, 7, 5)); // taken to 0x48.
		put_instr(32'h34, imm_op(mips_pkg::OP_ADDIU, 8, 0, 32'h33));
		put_instr(32'h38, imm_op(mips_pkg::OP_ADDIU, 12, 0, 32'h77));
		put_instr(32'h40, imm_op(mips_pkg::OP_ADDIU, 12, 0, 32'h66));
		put_instr(32'h48, imm_op(mips_pkg::OP_ADDIU, 9, 0, 32'h33));
		put_instr(32'h4c, imm_op(mips_pkg::OP_BNE, 8, 9, 4)); // not taken.
		put_instr(32'h50, imm_op(mips_pkg::OP_ADDIU, 10, 0, 32'h44));
		put_instr(32'h54, imm_op(mips_pkg::OP_ADDIU, 11, 0, 32'h55));
		put_instr(32'h58, jump_to(32'h58));
		put_instr(32'h60, imm_op(mips_pkg::OP_ADDIU, 12, 0, 32'h88));
		expect_wb(32'h00, 1, 32'h5);
		expect_wb(32'h04, 2, 32'h5);
		expect_wb(32'h0c, 3, 32'h11);
		expect_wb(32'h20, 5, 32'h6);
		expect_wb(32'h28, 6, 32'h22);
		expect_wb(32'h2c, 7, 32'h7);
		expect_wb(32'h34, 8, 32'h33);
		expect_wb(32'h48, 9, 32'h33);
		expect_wb(32'h50, 10, 32'h44);
		expect_wb(32'h54, 11, 32'h55);
		release_reset();
		finish_program();
	endtask

	task automatic counted_loop();
		begin_test();
		put_instr(32'h00, imm_op(mips_pkg::OP_ADDIU, 1, 0, 3));
		put_instr(32'h04, imm_op(mips_pkg::OP_SW, 1, 0, 32'h20));
		put_instr(32'h08, imm_op(mips_pkg::OP_ADDIU, 2, 0, 0));
		put_instr(32'h0c, jump_to(32'h18));
		put_instr(32'h10, imm_op(mips_pkg::OP_ADDIU, 3, 0, 32'h10));
		put_instr(32'h14, imm_op(mips_pkg::OP_ADDIU, 9, 0, 32'hbad));
		put_instr(32'h18, imm_op(mips_pkg::OP_LW, 4, 0, 32'h20));
		put_instr(32'h1c, imm_op(mips_pkg::OP_BEQ, 0, 4, 6)); // exits to 0x38.
		put_instr(32'h20, alu_r(mips_pkg::FN_ADDU, 2, 2, 3));
		put_instr(32'h24, imm_op(mips_pkg::OP_ADDIU, 4, 4, 32'hffff));
		put_instr(32'h28, imm_op(mips_pkg::OP_SW, 4, 0, 32'h20));
		put_instr(32'h2c, jump_to(32'h18));
		put_instr(32'h38, imm_op(mips_pkg::OP_SW, 2, 0, 32'h24));
		put_instr(32'h3c, imm_op(mips_pkg::OP_SW, 3, 0, 32'h28));
		put_instr(32'h40, jump_to(32'h40));
		expect_wb(32'h00, 1, 32'h3);
		expect_wb(32'h08, 2, 32'h0);
		expect_wb(32'h10, 3, 32'h10);
		expect_store(32'h20, 32'h3);
		for (int n = 3; n > 0; n--) begin
			expect_wb(32'h18, 4, n);
			expect_wb(32'h20, 2, 32'h10 * (4 - n));
			expect_wb(32'h24, 4, n - 1);
			expect_store(32'h20, n - 1);
		end
		expect_wb(32'h18, 4, 32'h0);
		expect_wb(32'h20, 2, 32'h40); // the delay slot runs on the exit pass too.
		expect_store(32'h24, 32'h40);
		expect_store(32'h28, 32'h10);
		release_reset();
		finish_program();
		check("dmem word 0x20", dmem[8], 32'h0);
		check("dmem word 0x24", dmem[9], 32'h40);
		check("dmem word 0x28", dmem[10], 32'h10);
	endtask

	initial begin
		rst_n = 1'b0;
		for (int i = 0; i < 256; i++)
			imem[i] = 32'h0;
		fetch_after_reset();
		alu_chain();
		load_use();
		branch_paths();
		counted_loop();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: tb.f
rtl/mips_pkg.sv
rtl/decode_if.sv
rtl/hazard_if.sv
rtl/decoder.sv
rtl/hazard_unit.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/cpu.sv
test/tb_cpu.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_cpu --Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
	exit 0
else
	exit 1
fi
